/* sim.f */
+incdir+include
verilog/spi_pkg.sv
verilog/spi_stream_fifo.sv
verilog/spi_csr.sv
verilog/spi_engine.sv
verilog/spi_top.sv
test/spi_checker.sv
test/spi_monitor.sv
test/tb_spi_top.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the SPI master testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module tb_spi_top \
    -Mdir obj_dir -o sim_spi
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_spi > run.log 2>&1
sim_status=$?
cat run.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TEST OK$" run.log; then
    exit 0
fi
echo "Pass message not found in run.log"
exit 1

/* test/spi_stim.txt */
# name sel bits clk_div tx_word slave_word no_tx
# bits is the transfer length (1 to 32); clk_div is the sclk half period minus one.
# The slave model is clocked, so clk_div is at least 1.
byte_sel0      0  8    1  000000a5 0000003c 0
nibble_sel1    1  4    2  fffffff9 12345676 0
one_bit_sel2   2  1    3  00000001 00000001 0
word_sel3      3  32   1  deadbeef 12345678 0
half_sel0      0  16   5  0000c3a5 0000f00d 0
bits13_sel1    1  13   7  ffff1abc 00005555 0
no_tx_sel2     2  8    1  00000000 000000ff 1
bits24_sel2    2  24   255 00a1b2c3 00c0ffee 0
bits31_sel3    3  31   4  7fffffff 2aaaaaaa 0

/* test/tb_spi_top.sv */
`include "spi_macros.svh"

module tb_spi_top
    import spi_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int timeout_cycles = 20000;

    logic                       clk = 1'b0;
    logic                       reset = 1'b1;
    reg_req_t                   req = '0;
    logic [`SPI_DATA_WIDTH-1:0] rdata;
    logic                       rvalid;
    logic                       sclk;
    logic                       mosi;
    logic                       miso = 1'b0;
    logic [`SPI_NUM_SEL-1:0]    csn;
    logic                       csn_active;
    logic                       interrupt;

    logic [`SPI_DATA_WIDTH-1:0] slave_word = '0;
    int                         slave_top = 0;
    int                         slave_idx = 0;
    logic                       sclk_q = 1'b0;
    logic                       cs_q = 1'b1;
    logic                       aborted = 1'b0;

    always #4 clk = ~clk;

    spi_top i_spi_top (
        .clk(clk), .reset(reset), .req(req), .rdata(rdata), .rvalid(rvalid),
        .sclk(sclk), .mosi(mosi), .miso(miso), .csn(csn), .csn_active(csn_active),
        .interrupt(interrupt)
    );

    spi_monitor i_mon (
        .clk(clk), .reset(reset), .sclk(sclk), .mosi(mosi), .csn(csn),
        .csn_active(csn_active)
    );

    // Mode 0 slave. It loads the top bit when csn falls and moves on after each falling sclk.
    always @(posedge clk) begin
        sclk_q <= sclk;
        cs_q   <= &csn;
        if (cs_q && !(&csn)) begin
            slave_idx <= slave_top;
            miso      <= slave_word[slave_top];
        end else if (sclk_q && !sclk && slave_idx > 0) begin
            slave_idx <= slave_idx - 1;
            miso      <= slave_word[slave_idx - 1];
        end
    end

    task automatic reg_write(input logic [`SPI_ADDR_WIDTH-1:0] addr,
                             input logic [`SPI_DATA_WIDTH-1:0] data);
        reg_req_t r;
        r       = '0;
        r.wr    = 1'b1;
        r.addr  = addr;
        r.wdata = data;
        @(posedge clk);
        req <= r;
        @(posedge clk);
        req <= '0;
    endtask

    task automatic reg_read(input logic [`SPI_ADDR_WIDTH-1:0] addr,
                            output logic [`SPI_DATA_WIDTH-1:0] data);
        reg_req_t r;
        bit       seen;
        int       i;
        r      = '0;
        r.rd   = 1'b1;
        r.addr = addr;
        data   = '0;
        seen   = 1'b0;
        @(posedge clk);
        req <= r;
        @(posedge clk);
        req <= '0;
        for (i = 0; i < timeout_cycles && !seen; i++) begin
            @(negedge clk);
            if (rvalid) begin
                seen = 1'b1;
                data = rdata;
            end
        end
        if (!seen) begin
            $display("Timeout: no read data came back from register %0d", addr);
            aborted = 1'b1;
        end
    endtask

    task automatic wait_interrupt(input string name);
        bit seen;
        int i;
        seen = 1'b0;
        for (i = 0; i < timeout_cycles && !seen; i++) begin
            @(negedge clk);
            seen = interrupt;
        end
        if (!seen) begin
            $display("Timeout: the interrupt never rose in test %s", name);
            aborted = 1'b1;
        end
    endtask

    task automatic run_transfer(input string name, input int sel, input int bits,
                                input int div, input logic [31:0] tx,
                                input logic [31:0] slave, input int no_tx);
        spi_cmd_t    cmd;
        logic [31:0] mask;
        logic [31:0] rx_word;
        logic [31:0] status;
        logic [7:0]  exp_status;
        mask        = 32'((64'h1 << bits) - 64'h1);
        cmd.sel     = 2'(sel);
        cmd.nbits   = 5'(bits - 1);
        cmd.clk_div = 8'(div);
        slave_word  = slave;
        slave_top   = bits - 1;
        i_mon.begin_test(name);
        reg_write(REG_IRQ, 32'h1);
        if (no_tx == 0) reg_write(REG_TX, tx);
        reg_write(REG_CMD, 32'(cmd));
        wait_interrupt(name);
        if (aborted) return;
        reg_read(REG_RX, rx_word);
        if (aborted) return;
        reg_read(REG_STATUS, status);
        if (aborted) return;
        exp_status = {4'b0001, 1'b0, no_tx != 0, no_tx == 0, 1'b1};
        i_mon.check_value("rx word", (no_tx != 0) ? 32'h0 : (slave & mask), rx_word);
        i_mon.check_value("status", 32'(exp_status), status);
        i_mon.check_pins(no_tx != 0, tx & mask, `SPI_NUM_SEL'(1 << sel));
        reg_write(REG_STATUS, 32'h0000_000e);  // Clears overflow, engine_error and done.
        i_mon.end_test();
    endtask

    task automatic run_overflow();
        logic [31:0] status;
        int          i;
        i_mon.begin_test("tx_overflow");
        for (i = 0; i <= `SPI_FIFO_DEPTH; i++) reg_write(REG_TX, 32'h5a00_0000 + 32'(i));
        reg_read(REG_STATUS, status);
        if (aborted) return;
        i_mon.check_value("status", 32'h39, status);  // tx_full, rx_empty, overflow, irq_en.
        reg_write(REG_STATUS, 32'h08);
        reg_read(REG_STATUS, status);
        if (aborted) return;
        i_mon.check_value("status after clear", 32'h31, status);
        i_mon.end_test();
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        string       name;
        int          sel;
        int          bits;
        int          div;
        int          no_tx;
        logic [31:0] tx;
        logic [31:0] slave;
        fd = $fopen("test/spi_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file test/spi_stim.txt");
            aborted = 1'b1;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        while (!aborted && fd != 0 && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %d %d %d %h %h %d", name, sel, bits, div, tx, slave,
                            no_tx);
                if (n == 7) begin
                    run_transfer(name, sel, bits, div, tx, slave, no_tx);
                end else begin
                    $display("Stimulus line could not be parsed: %s", line);
                    aborted = 1'b1;
                end
            end
        end
        if (fd != 0) $fclose(fd);
        if (!aborted) run_overflow();
        i_mon.report_counts();
        if (aborted || i_mon.fail_count != 0 || i_mon.pass_count == 0 ||
            i_spi_top.u_checker.assert_fails != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule

/* test/spi_monitor.sv */
`include "spi_macros.svh"

module spi_monitor (
    input logic                    clk,
    input logic                    reset,
    input logic                    sclk,
    input logic                    mosi,
    input logic [`SPI_NUM_SEL-1:0] csn,
    input logic                    csn_active
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`SPI_DATA_WIDTH-1:0] mosi_bits = '0;
    logic [`SPI_NUM_SEL-1:0]    csn_low = '0;  // Every select seen low in this transfer.
    logic                       sclk_q = 1'b0;
    logic                       active_q = 1'b0;
    int                         transfers = 0;
    int                         mismatches = 0;

    string       test_name = "";
    int          transfers_at_start = 0;
    int          mismatches_at_start = 0;
    int          checks = 0;
    logic [31:0] first_expected = '0;
    logic [31:0] first_actual = '0;
    bit          test_failed = 1'b0;
    int          pass_count = 0;
    int          fail_count = 0;

    always @(posedge clk) begin
        if (reset) begin
            sclk_q   <= 1'b0;
            active_q <= 1'b0;
        end else begin
            sclk_q   <= sclk;
            active_q <= csn_active;
            if (csn_active && !active_q) begin
                mosi_bits <= '0;
                csn_low   <= ~csn;
                transfers <= transfers + 1;
            end else if (csn_active) begin
                csn_low <= csn_low | ~csn;
            end
            if (sclk && !sclk_q) mosi_bits <= {mosi_bits[`SPI_DATA_WIDTH-2:0], mosi};
            if (csn_active != (csn != '1)) mismatches <= mismatches + 1;
        end
    end

    task automatic begin_test(input string name);
        test_name           = name;
        transfers_at_start  = transfers;
        mismatches_at_start = mismatches;
        checks              = 0;
        test_failed         = 1'b0;
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (checks == 0) begin
            first_expected = expected;
            first_actual   = actual;
        end
        checks++;
        if (actual !== expected) begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
            test_failed = 1'b1;
        end
    endtask

    task automatic check_pins(input bit no_transfer, input logic [31:0] exp_mosi,
                              input logic [`SPI_NUM_SEL-1:0] exp_csn_low);
        check_value("transfers", no_transfer ? 32'd0 : 32'd1, 32'(transfers - transfers_at_start));
        if (!no_transfer) begin
            check_value("mosi bits", exp_mosi, mosi_bits);
            check_value("csn low", 32'(exp_csn_low), 32'(csn_low));
        end
        if (mismatches != mismatches_at_start) begin
            $display("Test %s: csn_active disagreed with csn in %0d cycles", test_name,
                     mismatches - mismatches_at_start);
            test_failed = 1'b1;
        end
    endtask

    task automatic end_test();
        if (test_failed) begin
            fail_count++;
        end else begin
            pass_count++;
            $display("[PASS] %s: expected %h, actual %h", test_name, first_expected,
                     first_actual);
        end
    endtask

    task automatic report_counts();
        $display("Tests run %0d, passed %0d, failed %0d", pass_count + fail_count, pass_count,
                 fail_count);
    endtask

endmodule

/* test/spi_checker.sv */
`include "spi_macros.svh"

module spi_checker (
    input logic                    clk,
    input logic                    reset,
    input logic                    sclk,
    input logic [`SPI_NUM_SEL-1:0] csn,
    input logic                    csn_active,
    input logic                    interrupt
);
    timeunit 1ns;
    timeprecision 1ps;

    int assert_fails = 0;

    sclk_idle_low: assert property (@(posedge clk) disable iff (reset) !csn_active |-> !sclk)
        else begin
            assert_fails++;
            $error("sclk is high while no chip select is active");
        end

    csn_idle_high: assert property (@(posedge clk) disable iff (reset)
                                    !csn_active |-> (csn == '1))
        else begin
            assert_fails++;
            $error("A chip select is low while csn_active is low");
        end

    irq_after_reset: assert property (@(posedge clk) reset |=> !interrupt)
        else begin
            assert_fails++;
            $error("interrupt is high in the cycle after reset");
        end

endmodule

bind spi_top spi_checker u_checker (
    .clk(clk), .reset(reset), .sclk(sclk), .csn(csn), .csn_active(csn_active),
    .interrupt(interrupt)
);

/* verilog/spi_top.sv */
`include "spi_macros.svh"

module spi_top
    import spi_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  reg_req_t                   req,
    output logic [`SPI_DATA_WIDTH-1:0] rdata,
    output logic                       rvalid,
    output logic                       sclk,
    output logic                       mosi,
    input  logic                       miso,
    output logic [`SPI_NUM_SEL-1:0]    csn,
    output logic                       csn_active,
    output logic                       interrupt
);
    typedef logic [`SPI_DATA_WIDTH-1:0] word_t;

    spi_cmd_t cmd_data, cmd_head;
    word_t    tx_data, tx_head, rx_data, rx_head;
    logic     cmd_push, cmd_pop, cmd_full, cmd_empty;
    logic     tx_push, tx_pop, tx_full, tx_empty;
    logic     rx_push, rx_pop, rx_full, rx_empty;
    logic     done, error, busy;

    spi_csr csr (
        .clk(clk), .reset(reset), .req(req), .rdata(rdata), .rvalid(rvalid),
        .cmd_push(cmd_push), .cmd_data(cmd_data), .cmd_full(cmd_full),
        .tx_push(tx_push), .tx_data(tx_data), .tx_full(tx_full),
        .rx_pop(rx_pop), .rx_head(rx_head), .rx_empty(rx_empty),
        .done(done), .error(error), .busy(busy), .interrupt(interrupt)
    );

    spi_stream_fifo #(.payload_t(spi_cmd_t), .depth(`SPI_FIFO_DEPTH)) cmd_fifo (
        .clk(clk), .reset(reset), .push(cmd_push), .push_data(cmd_data),
        .pop(cmd_pop), .head(cmd_head), .full(cmd_full), .empty(cmd_empty)
    );

    spi_stream_fifo #(.payload_t(word_t), .depth(`SPI_FIFO_DEPTH)) tx_fifo (
        .clk(clk), .reset(reset), .push(tx_push), .push_data(tx_data),
        .pop(tx_pop), .head(tx_head), .full(tx_full), .empty(tx_empty)
    );

    spi_stream_fifo #(.payload_t(word_t), .depth(`SPI_FIFO_DEPTH)) rx_fifo (
        .clk(clk), .reset(reset), .push(rx_push), .push_data(rx_data),
        .pop(rx_pop), .head(rx_head), .full(rx_full), .empty(rx_empty)
    );

    spi_engine engine (
        .clk(clk), .reset(reset),
        .cmd_head(cmd_head), .cmd_empty(cmd_empty), .cmd_pop(cmd_pop),
        .tx_head(tx_head), .tx_empty(tx_empty), .tx_pop(tx_pop),
        .rx_push(rx_push), .rx_data(rx_data), .rx_full(rx_full),
        .sclk(sclk), .mosi(mosi), .miso(miso), .csn(csn), .csn_active(csn_active),
        .done(done), .error(error), .busy(busy)
    );

endmodule

/* verilog/spi_engine.sv */
`include "spi_macros.svh"

module spi_engine
    import spi_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  spi_cmd_t                   cmd_head,
    input  logic                       cmd_empty,
    output logic                       cmd_pop,
    input  logic [`SPI_DATA_WIDTH-1:0] tx_head,
    input  logic                       tx_empty,
    output logic                       tx_pop,
    output logic                       rx_push,
    output logic [`SPI_DATA_WIDTH-1:0] rx_data,
    input  logic                       rx_full,
    output logic                       sclk,
    output logic                       mosi,
    input  logic                       miso,
    output logic [`SPI_NUM_SEL-1:0]    csn,
    output logic                       csn_active,
    output logic                       done,
    output logic                       error,
    output logic                       busy
);
    typedef enum logic [1:0] {st_idle, st_assert, st_shift, st_finish} state_t;

    state_t                     state;
    logic                       start;
    logic                       half_done;
    logic                       rise;
    logic                       fall;
    logic                       last_bit;
    logic [4:0]                 align;
    logic [7:0]                 clk_div;
    logic [7:0]                 div_cnt;
    logic [4:0]                 bit_cnt;
    logic [`SPI_DATA_WIDTH-1:0] tx_shift;
    logic [`SPI_DATA_WIDTH-1:0] rx_shift;

    // A push still in flight could fill the receive FIFO, so wait it out.
    assign start     = (state == st_idle) && !cmd_empty && !rx_full && !rx_push;
    assign cmd_pop   = start;
    assign tx_pop    = start && !tx_empty;
    assign half_done = (div_cnt == clk_div);
    assign rise      = half_done && ((state == st_assert) || (state == st_shift && !sclk));
    assign fall      = half_done && (state == st_shift) && sclk;
    assign last_bit  = (bit_cnt == '0);
    assign align     = 5'(`SPI_DATA_WIDTH - 1) - cmd_head.nbits;  // Puts bit nbits on top.
    assign busy      = (state != st_idle);
    assign rx_data   = rx_shift;

    always_ff @(posedge clk) begin
        if (start) begin
            clk_div  <= cmd_head.clk_div;
            bit_cnt  <= cmd_head.nbits;
            div_cnt  <= '0;
            tx_shift <= tx_head << align;
            rx_shift <= '0;  // Upper bits of the received word stay zero.
        end else if (busy) begin
            div_cnt <= half_done ? '0 : div_cnt + 1'b1;
            if (rise) rx_shift <= {rx_shift[`SPI_DATA_WIDTH-2:0], miso};
            if (fall && !last_bit) begin
                bit_cnt  <= bit_cnt - 1'b1;
                tx_shift <= tx_shift << 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            sclk       <= 1'b0;
            mosi       <= 1'b0;
            csn        <= '1;
            csn_active <= 1'b0;
            rx_push    <= 1'b0;
            done       <= 1'b0;
            error      <= 1'b0;
        end else begin
            rx_push <= 1'b0;
            done    <= 1'b0;
            error   <= 1'b0;
            case (state)
                st_idle: begin
                    if (start && tx_empty) begin
                        error <= 1'b1;  // Command is dropped.
                    end else if (start) begin
                        state      <= st_assert;
                        csn        <= ~(`SPI_NUM_SEL'(1) << cmd_head.sel);
                        csn_active <= 1'b1;
                        mosi       <= tx_head[cmd_head.nbits];
                    end
                end
                st_assert: begin
                    if (rise) begin
                        sclk  <= 1'b1;
                        state <= st_shift;
                    end
                end
                st_shift: begin
                    if (rise) begin
                        sclk <= 1'b1;
                    end else if (fall) begin
                        sclk <= 1'b0;
                        if (last_bit) state <= st_finish;
                        else mosi <= tx_shift[`SPI_DATA_WIDTH-2];
                    end
                end
                default: begin
                    if (half_done) begin  // Hold time after the last falling edge.
                        state      <= st_idle;
                        csn        <= '1;
                        csn_active <= 1'b0;
                        mosi       <= 1'b0;
                        rx_push    <= 1'b1;
                        done       <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

/* verilog/spi_csr.sv */
`include "spi_macros.svh"

module spi_csr
    import spi_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  reg_req_t                   req,
    output logic [`SPI_DATA_WIDTH-1:0] rdata,
    output logic                       rvalid,
    output logic                       cmd_push,
    output spi_cmd_t                   cmd_data,
    input  logic                       cmd_full,
    output logic                       tx_push,
    output logic [`SPI_DATA_WIDTH-1:0] tx_data,
    input  logic                       tx_full,
    output logic                       rx_pop,
    input  logic [`SPI_DATA_WIDTH-1:0] rx_head,
    input  logic                       rx_empty,
    input  logic                       done,
    input  logic                       error,
    input  logic                       busy,
    output logic                       interrupt
);
    logic        wr_cmd;
    logic        wr_tx;
    logic        wr_status;
    logic        wr_irq;
    logic        overflow;
    logic        engine_error;
    logic        done_flag;
    logic        irq_en;
    spi_status_t status;
    spi_status_t clear;

    assign wr_cmd    = req.wr && (req.addr == REG_CMD);
    assign wr_tx     = req.wr && (req.addr == REG_TX);
    assign wr_status = req.wr && (req.addr == REG_STATUS);
    assign wr_irq    = req.wr && (req.addr == REG_IRQ);
    assign clear     = spi_status_t'(req.wdata[$bits(spi_status_t)-1:0]);

    assign cmd_push = wr_cmd && !cmd_full;
    assign cmd_data = spi_cmd_t'(req.wdata[$bits(spi_cmd_t)-1:0]);
    assign tx_push  = wr_tx && !tx_full;
    assign tx_data  = req.wdata;
    assign rx_pop   = req.rd && (req.addr == REG_RX) && !rx_empty;

    always_comb begin
        status.busy         = busy;
        status.cmd_full     = cmd_full;
        status.tx_full      = tx_full;
        status.rx_empty     = rx_empty;
        status.overflow     = overflow;
        status.engine_error = engine_error;
        status.done         = done_flag;
        status.irq_en       = irq_en;
    end

    assign interrupt = irq_en && (done_flag || engine_error);

    always_ff @(posedge clk) begin
        if (reset) begin
            overflow     <= 1'b0;
            engine_error <= 1'b0;
            done_flag    <= 1'b0;
            irq_en       <= 1'b0;
            rvalid       <= 1'b0;
        end else begin
            if ((wr_cmd && cmd_full) || (wr_tx && tx_full)) overflow <= 1'b1;
            else if (wr_status && clear.overflow) overflow <= 1'b0;
            if (error) engine_error <= 1'b1;  // A new event wins over a clear.
            else if (wr_status && clear.engine_error) engine_error <= 1'b0;
            if (done) done_flag <= 1'b1;
            else if (wr_status && clear.done) done_flag <= 1'b0;
            if (wr_irq) irq_en <= req.wdata[0];
            rvalid <= req.rd;
        end
    end

    always_ff @(posedge clk) begin
        if (req.rd) begin
            case (req.addr)
                REG_RX:     rdata <= rx_empty ? '0 : rx_head;
                REG_STATUS: rdata <= `SPI_DATA_WIDTH'(status);
                REG_IRQ:    rdata <= `SPI_DATA_WIDTH'(irq_en);
                default:    rdata <= '0;
            endcase
        end
    end

endmodule

/* verilog/spi_stream_fifo.sv */
module spi_stream_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     full,
    output logic     empty
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);
    localparam logic [ptr_w:0] full_count = (ptr_w + 1)'(depth);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        return (ptr == last_ptr) ? '0 : ptr + 1'b1;  // Wraps for any depth.
    endfunction

    assign full    = (count == full_count);
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

endmodule

/* verilog/spi_pkg.sv */
`include "spi_macros.svh"

package spi_pkg;

    typedef struct packed {
        logic [`SPI_SEL_WIDTH-1:0] sel;
        logic [4:0]                nbits;    // Number of bits minus one.
        logic [7:0]                clk_div;  // Half period of sclk minus one, in clocks.
    } spi_cmd_t;

    typedef struct packed {
        logic                       wr;
        logic                       rd;
        logic [`SPI_ADDR_WIDTH-1:0] addr;
        logic [`SPI_DATA_WIDTH-1:0] wdata;
    } reg_req_t;

    // Bit 7 is busy, bit 0 is irq_en.
    typedef struct packed {
        logic busy;
        logic cmd_full;
        logic tx_full;
        logic rx_empty;
        logic overflow;      // Sticky.
        logic engine_error;  // Sticky.
        logic done;          // Sticky.
        logic irq_en;
    } spi_status_t;

    localparam logic [`SPI_ADDR_WIDTH-1:0] REG_CMD    = 0;
    localparam logic [`SPI_ADDR_WIDTH-1:0] REG_TX     = 1;
    localparam logic [`SPI_ADDR_WIDTH-1:0] REG_RX     = 2;
    localparam logic [`SPI_ADDR_WIDTH-1:0] REG_STATUS = 3;
    localparam logic [`SPI_ADDR_WIDTH-1:0] REG_IRQ    = 4;

endpackage

/* include/spi_macros.svh */
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// Width of a data word on the register port and in the shift engine.
`define SPI_DATA_WIDTH 32

`define SPI_NUM_SEL    4
`define SPI_SEL_WIDTH  2

`define SPI_FIFO_DEPTH 4  // Entries in each of the three queues.

`define SPI_ADDR_WIDTH 4

`endif
